// File: hdl/trig_pkg.sv
package trig_pkg;

    localparam int CNT_W = 32;                  // counters, delay, width, divider
    localparam int POS_W = 32;                  // encoder position

    // cycle counts, pulse counts, divider ratio, delay and width
    typedef logic [CNT_W-1:0] cnt_t;

    // signed encoder position
    typedef logic signed [POS_W-1:0] pos_t;

    // trigger source select
    typedef enum logic [1:0] {
        MODE_SOFT    = 2'd0,                    // periodic soft generator
        MODE_ENCODER = 2'd1,                    // divided encoder steps
        MODE_IO      = 2'd2,                    // external io edge
        MODE_OFF     = 2'd3                     // no source
    } trig_mode_e;

    // output shaper states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_DELAY = 2'd1,
        ST_PULSE = 2'd2
    } shaper_state_e;

    localparam int SYNC_STAGES_DEF = 2;         // flops per async input

endpackage

// File: hdl/encoder_divider.sv
`timescale 1ns/1ps

module encoder_divider #(
    parameter int SYNC_STAGES = trig_pkg::SYNC_STAGES_DEF
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                encoder_a_i,
    input  logic                encoder_b_i,
    input  trig_pkg::cnt_t      enc_div_i,
    input  logic                enc_clr_i,
    output logic                enc_trig_o,
    output trig_pkg::pos_t      enc_location_o
);

    logic [SYNC_STAGES-1:0] a_sync;             // a line synchronizer
    logic [SYNC_STAGES-1:0] b_sync;             // b line synchronizer
    logic                   a_s;
    logic                   b_s;
    logic                   a_d;                // synchronized a, one cycle late
    logic                   a_rise;
    logic                   fwd_step;
    logic                   rev_step;
    trig_pkg::cnt_t         div_eff;
    trig_pkg::cnt_t         step_cnt;           // forward steps since last trigger
    trig_pkg::cnt_t         step_nxt;

    assign a_s = a_sync[SYNC_STAGES-1];
    assign b_s = b_sync[SYNC_STAGES-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            a_sync <= '0;
            b_sync <= '0;
            a_d    <= 1'b0;
        end else begin
            a_sync <= {a_sync[SYNC_STAGES-2:0], encoder_a_i};
            b_sync <= {b_sync[SYNC_STAGES-2:0], encoder_b_i};
            a_d    <= a_s;
        end
    end

    // direction is taken from b at the moment a rises
    assign a_rise   = a_s & ~a_d;
    assign fwd_step = a_rise & ~b_s;
    assign rev_step = a_rise & b_s;

    assign div_eff  = (enc_div_i == '0) ? trig_pkg::cnt_t'(1) : enc_div_i;
    assign step_nxt = step_cnt + trig_pkg::cnt_t'(1);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enc_location_o <= '0;
            step_cnt       <= '0;
            enc_trig_o     <= 1'b0;
        end else if (enc_clr_i) begin
            enc_location_o <= '0;
            step_cnt       <= '0;
            enc_trig_o     <= 1'b0;
        end else begin
            enc_trig_o <= 1'b0;
            if (fwd_step) begin
                enc_location_o <= enc_location_o + 32'sd1;
                if (step_nxt >= div_eff) begin     // full division reached
                    step_cnt   <= '0;
                    enc_trig_o <= 1'b1;
                end else begin
                    step_cnt <= step_nxt;
                end
            end else if (rev_step) begin
                enc_location_o <= enc_location_o - 32'sd1;  // no trigger going back
            end
        end
    end

    // each trigger needs a fresh a rise, so pulses are always isolated
    a_enc_trig_single: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        enc_trig_o |=> !enc_trig_o
    ) else $error("encoder trigger high on two consecutive cycles");

endmodule

// File: hdl/soft_trigger_gen.sv
`timescale 1ns/1ps

module soft_trigger_gen (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                soft_en_i,
    input  trig_pkg::cnt_t      soft_cycle_i,
    input  trig_pkg::cnt_t      soft_num_i,
    output logic                soft_trig_o
);

    logic               en_d;
    logic               en_rise;
    logic               running;            // burst in progress
    logic               period_hit;
    logic               burst_done;
    trig_pkg::cnt_t     cycle_eff;
    trig_pkg::cnt_t     per_cnt;            // cycles since last pulse
    trig_pkg::cnt_t     pulse_cnt;          // pulses emitted in this burst
    trig_pkg::cnt_t     pulse_nxt;

    assign en_rise    = soft_en_i & ~en_d;
    assign cycle_eff  = (soft_cycle_i == '0) ? trig_pkg::cnt_t'(1) : soft_cycle_i;
    assign period_hit = running & (per_cnt >= cycle_eff);

    // count including the pulse about to be issued
    assign pulse_nxt  = en_rise ? trig_pkg::cnt_t'(1) : pulse_cnt + trig_pkg::cnt_t'(1);
    assign burst_done = (soft_num_i != '0) && (pulse_nxt >= soft_num_i);  // 0 = endless

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_d        <= 1'b0;
            running     <= 1'b0;
            per_cnt     <= '0;
            pulse_cnt   <= '0;
            soft_trig_o <= 1'b0;
        end else begin
            en_d        <= soft_en_i;
            soft_trig_o <= 1'b0;
            if (!soft_en_i) begin               // stop and rearm
                running   <= 1'b0;
                per_cnt   <= '0;
                pulse_cnt <= '0;
            end else if (en_rise || period_hit) begin
                soft_trig_o <= 1'b1;
                per_cnt     <= trig_pkg::cnt_t'(1);
                pulse_cnt   <= pulse_nxt;
                running     <= ~burst_done;
            end else if (running) begin
                per_cnt <= per_cnt + trig_pkg::cnt_t'(1);
            end
        end
    end

    a_soft_quiet_when_off: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !soft_en_i |=> !soft_trig_o
    ) else $error("soft trigger issued after enable was low");

endmodule

// File: hdl/trigger_shaper.sv
`timescale 1ns/1ps

module trigger_shaper #(
    parameter int SYNC_STAGES = trig_pkg::SYNC_STAGES_DEF
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    soft_trig_i,
    input  logic                    enc_trig_i,
    input  logic                    io_input_i,
    input  trig_pkg::trig_mode_e    trig_mode_i,
    input  logic                    io_polar_i,
    input  logic                    out_polar_i,
    input  trig_pkg::cnt_t          trig_delay_i,
    input  trig_pkg::cnt_t          trig_width_i,
    input  logic                    status_clr_i,
    output logic                    trigger_o,
    output trig_pkg::cnt_t          trig_cnt_o,
    output trig_pkg::cnt_t          drop_cnt_o
);

    logic [SYNC_STAGES-1:0]     io_sync;
    logic                       io_pol;         // io with polarity applied
    logic                       io_pol_d;
    logic                       io_edge;
    logic                       sel_trig;       // selected one-cycle pulse
    trig_pkg::shaper_state_e    state_q;
    trig_pkg::cnt_t             cyc_cnt;        // shared delay/width counter
    trig_pkg::cnt_t             width_eff;
    trig_pkg::cnt_t             pulse_run;      // active cycles so far in this run

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            io_sync  <= '0;
            io_pol_d <= 1'b0;
        end else begin
            io_sync  <= {io_sync[SYNC_STAGES-2:0], io_input_i};
            io_pol_d <= io_pol;
        end
    end

    // polar 1 turns a falling input edge into a rise here
    assign io_pol  = io_sync[SYNC_STAGES-1] ^ io_polar_i;
    assign io_edge = io_pol & ~io_pol_d;

    always_comb begin
        case (trig_mode_i)
            trig_pkg::MODE_SOFT:    sel_trig = soft_trig_i;
            trig_pkg::MODE_ENCODER: sel_trig = enc_trig_i;
            trig_pkg::MODE_IO:      sel_trig = io_edge;
            default:                sel_trig = 1'b0;    // off
        endcase
    end

    assign width_eff = (trig_width_i == '0) ? trig_pkg::cnt_t'(1) : trig_width_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= trig_pkg::ST_IDLE;
            cyc_cnt <= '0;
        end else begin
            case (state_q)
                trig_pkg::ST_IDLE: begin
                    if (sel_trig) begin
                        state_q <= (trig_delay_i == '0) ? trig_pkg::ST_PULSE : trig_pkg::ST_DELAY;
                        cyc_cnt <= trig_pkg::cnt_t'(1);
                    end
                end
                trig_pkg::ST_DELAY: begin
                    if (cyc_cnt >= trig_delay_i) begin
                        state_q <= trig_pkg::ST_PULSE;
                        cyc_cnt <= trig_pkg::cnt_t'(1);
                    end else begin
                        cyc_cnt <= cyc_cnt + trig_pkg::cnt_t'(1);
                    end
                end
                trig_pkg::ST_PULSE: begin
                    if (cyc_cnt >= width_eff) begin     // last active cycle
                        state_q <= trig_pkg::ST_IDLE;
                        cyc_cnt <= '0;
                    end else begin
                        cyc_cnt <= cyc_cnt + trig_pkg::cnt_t'(1);
                    end
                end
                default: begin
                    state_q <= trig_pkg::ST_IDLE;
                    cyc_cnt <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trig_cnt_o <= '0;
            drop_cnt_o <= '0;
        end else if (status_clr_i) begin
            trig_cnt_o <= '0;
            drop_cnt_o <= '0;
        end else if (sel_trig) begin
            if (state_q == trig_pkg::ST_IDLE) begin
                trig_cnt_o <= trig_cnt_o + trig_pkg::cnt_t'(1);
            end else begin
                drop_cnt_o <= drop_cnt_o + trig_pkg::cnt_t'(1);   // busy, overrun
            end
        end
    end

    assign trigger_o = (state_q == trig_pkg::ST_PULSE) ^ out_polar_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pulse_run <= '0;
        end else begin
            pulse_run <= (state_q == trig_pkg::ST_PULSE) ? pulse_run + trig_pkg::cnt_t'(1) : '0;
        end
    end

    a_pulse_len: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (state_q == trig_pkg::ST_PULSE) |-> (pulse_run < width_eff)
    ) else $error("output active longer than the programmed width");

endmodule

// File: hdl/trigger_manage_top.sv
`timescale 1ns/1ps

module trigger_manage_top #(
    parameter int SYNC_STAGES = trig_pkg::SYNC_STAGES_DEF
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    io_input_i,
    input  logic                    encoder_a_i,
    input  logic                    encoder_b_i,
    input  trig_pkg::trig_mode_e    trig_mode_i,
    input  logic                    io_polar_i,
    input  logic                    out_polar_i,
    input  trig_pkg::cnt_t          trig_delay_i,
    input  trig_pkg::cnt_t          trig_width_i,
    input  logic                    soft_en_i,
    input  trig_pkg::cnt_t          soft_cycle_i,
    input  trig_pkg::cnt_t          soft_num_i,
    input  trig_pkg::cnt_t          enc_div_i,
    input  logic                    enc_clr_i,
    input  logic                    status_clr_i,
    output logic                    trigger_o,
    output trig_pkg::cnt_t          trig_cnt_o,
    output trig_pkg::cnt_t          drop_cnt_o,
    output trig_pkg::pos_t          enc_location_o
);

    logic enc_trig;                     // one pulse per enc_div forward steps
    logic soft_trig;                    // periodic burst pulse

    encoder_divider #(
        .SYNC_STAGES    (SYNC_STAGES)
    ) encoder_divider_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .encoder_a_i    (encoder_a_i),
        .encoder_b_i    (encoder_b_i),
        .enc_div_i      (enc_div_i),
        .enc_clr_i      (enc_clr_i),
        .enc_trig_o     (enc_trig),
        .enc_location_o (enc_location_o)
    );

    soft_trigger_gen soft_trigger_gen_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .soft_en_i      (soft_en_i),
        .soft_cycle_i   (soft_cycle_i),
        .soft_num_i     (soft_num_i),
        .soft_trig_o    (soft_trig)
    );

    trigger_shaper #(
        .SYNC_STAGES    (SYNC_STAGES)
    ) trigger_shaper_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .soft_trig_i    (soft_trig),
        .enc_trig_i     (enc_trig),
        .io_input_i     (io_input_i),
        .trig_mode_i    (trig_mode_i),
        .io_polar_i     (io_polar_i),
        .out_polar_i    (out_polar_i),
        .trig_delay_i   (trig_delay_i),
        .trig_width_i   (trig_width_i),
        .status_clr_i   (status_clr_i),
        .trigger_o      (trigger_o),
        .trig_cnt_o     (trig_cnt_o),
        .drop_cnt_o     (drop_cnt_o)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 50       // 100 ns period
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

endmodule

// File: sim/trigger_manage_tb.sv
`timescale 1ns/1ps

module trigger_manage_tb;

    localparam int unsigned SEED = 32'hc2fdc1a6;
    localparam int TIMEOUT_CYCLES = 20000;      // all tests together need under 2000
    localparam int DRIVE_SKEW = 10;             // ns after the rising edge

    logic                   clk;
    logic                   rst_n;
    logic                   io_input;
    logic                   encoder_a;
    logic                   encoder_b;
    trig_pkg::trig_mode_e   trig_mode;
    logic                   io_polar;
    logic                   out_polar;
    trig_pkg::cnt_t         trig_delay;
    trig_pkg::cnt_t         trig_width;
    logic                   soft_en;
    trig_pkg::cnt_t         soft_cycle;
    trig_pkg::cnt_t         soft_num;
    trig_pkg::cnt_t         enc_div;
    logic                   enc_clr;
    logic                   status_clr;
    logic                   trigger;
    trig_pkg::cnt_t         trig_cnt;
    trig_pkg::cnt_t         drop_cnt;
    trig_pkg::pos_t         enc_location;

    trig_pkg::cnt_t         exp_width;          // width every active run must have
    trig_pkg::cnt_t         run_len = '0;
    int                     pulse_count = 0;    // finished active runs since start
    int                     cycle_cnt = 0;
    int unsigned            seed_dummy;

    tb_clock_gen clock_gen_i (.clk_o(clk));

    trigger_manage_top #(
        .SYNC_STAGES    (trig_pkg::SYNC_STAGES_DEF)
    ) trigger_manage_top_i (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .io_input_i     (io_input),
        .encoder_a_i    (encoder_a),
        .encoder_b_i    (encoder_b),
        .trig_mode_i    (trig_mode),
        .io_polar_i     (io_polar),
        .out_polar_i    (out_polar),
        .trig_delay_i   (trig_delay),
        .trig_width_i   (trig_width),
        .soft_en_i      (soft_en),
        .soft_cycle_i   (soft_cycle),
        .soft_num_i     (soft_num),
        .enc_div_i      (enc_div),
        .enc_clr_i      (enc_clr),
        .status_clr_i   (status_clr),
        .trigger_o      (trigger),
        .trig_cnt_o     (trig_cnt),
        .drop_cnt_o     (drop_cnt),
        .enc_location_o (enc_location)
    );

    task automatic stop_sim();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_sim();
        end
    endtask

    task automatic compare_cnt(input trig_pkg::cnt_t got, input trig_pkg::cnt_t exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            stop_sim();
        end
    endtask

    task automatic compare_pos(input trig_pkg::pos_t got, input trig_pkg::pos_t exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            stop_sim();
        end
    endtask

    // sampled on the falling edge, away from every update
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (trigger === ~out_polar) begin
                run_len = run_len + trig_pkg::cnt_t'(1);
            end else if (run_len != '0) begin
                compare_cnt(run_len, exp_width, "active run length of trigger_o");
                pulse_count = pulse_count + 1;
                run_len = '0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_sim();
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_SKEW);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic wait_pulses(input int target, input int limit);
        int waited;
        waited = 0;
        while (pulse_count < target && waited < limit) begin
            next_cycle();
            waited++;
        end
        if (pulse_count < target) begin
            $display("output pulse count stuck at %0d, waited for %0d during %0d cycles",
                     pulse_count, target, limit);
            stop_sim();
        end
    endtask

    function automatic trig_pkg::cnt_t random_delay();
        return trig_pkg::cnt_t'($urandom % 6);  // 0 to 5
    endfunction

    task automatic clear_status();
        status_clr = 1'b1;
        next_cycle();
        status_clr = 1'b0;
        next_cycle();
    endtask

    task automatic setup_soft(input trig_pkg::cnt_t num, input trig_pkg::cnt_t period,
                              input trig_pkg::cnt_t delay, input trig_pkg::cnt_t width);
        trig_mode  = trig_pkg::MODE_SOFT;
        soft_num   = num;
        soft_cycle = period;
        trig_delay = delay;
        trig_width = width;
        exp_width  = width;
        clear_status();
    endtask

    // one quadrature step, both lines low before and after
    task automatic enc_step(input logic fwd);
        encoder_a = fwd ? 1'b1 : 1'b0;
        encoder_b = fwd ? 1'b0 : 1'b1;
        wait_cycles(4 + int'($urandom % 8));
        encoder_a = 1'b1;
        encoder_b = 1'b1;
        wait_cycles(4 + int'($urandom % 8));
        encoder_a = fwd ? 1'b0 : 1'b1;
        encoder_b = fwd ? 1'b1 : 1'b0;
        wait_cycles(4 + int'($urandom % 8));
        encoder_a = 1'b0;
        encoder_b = 1'b0;
        wait_cycles(4 + int'($urandom % 8));
    endtask

    task automatic test_reset();
        compare_bit(trigger, 1'b0, "trigger_o after reset");
        compare_cnt(trig_cnt, '0, "trig_cnt_o after reset");
        compare_cnt(drop_cnt, '0, "drop_cnt_o after reset");
        compare_pos(enc_location, '0, "enc_location_o after reset");
    endtask

    task automatic test_soft_burst();
        int start;
        start = pulse_count;
        setup_soft(4, 30, random_delay(), 6);
        soft_en = 1'b1;
        wait_pulses(start + 4, 400);
        wait_cycles(90);                        // room for a stray fifth pulse
        compare_cnt(trig_pkg::cnt_t'(pulse_count - start), 4, "soft burst pulses");
        compare_cnt(trig_cnt, 4, "trig_cnt_o after soft burst");
        compare_cnt(drop_cnt, 0, "drop_cnt_o after soft burst");
        soft_en = 1'b0;
        next_cycle();
        clear_status();
        compare_cnt(trig_cnt, 0, "trig_cnt_o after status clear");
        compare_cnt(drop_cnt, 0, "drop_cnt_o after status clear");
    endtask

    task automatic test_encoder();
        int start;
        start      = pulse_count;
        trig_mode  = trig_pkg::MODE_ENCODER;
        enc_div    = 4;
        trig_delay = random_delay();
        trig_width = 3;
        exp_width  = 3;
        clear_status();
        repeat (16) enc_step(1'b1);
        wait_pulses(start + 4, 200);
        compare_pos(enc_location, 16, "position after 16 forward steps");
        repeat (6) enc_step(1'b0);
        wait_cycles(20);
        compare_cnt(trig_pkg::cnt_t'(pulse_count - start), 4, "encoder pulses");
        compare_pos(enc_location, 10, "position after 6 reverse steps");
        compare_cnt(trig_cnt, 4, "trig_cnt_o after encoder steps");
        compare_cnt(drop_cnt, 0, "drop_cnt_o after encoder steps");
        enc_clr = 1'b1;
        next_cycle();
        enc_clr = 1'b0;
        next_cycle();
        compare_pos(enc_location, 0, "position after enc_clr");
    endtask

    task automatic test_io_polarity();
        int start;
        trig_mode = trig_pkg::MODE_OFF;         // park the line high first
        io_input  = 1'b1;
        wait_cycles(4);
        io_polar  = 1'b1;
        wait_cycles(4);
        start      = pulse_count;
        trig_mode  = trig_pkg::MODE_IO;
        trig_delay = random_delay();
        trig_width = 3;
        exp_width  = 3;
        clear_status();
        repeat (3) begin
            io_input = 1'b0;
            wait_cycles(12);
            io_input = 1'b1;                    // rising edge, must stay quiet
            wait_cycles(12);
        end
        wait_pulses(start + 3, 40);
        wait_cycles(12);
        compare_cnt(trig_pkg::cnt_t'(pulse_count - start), 3, "io pulses");
        compare_cnt(trig_cnt, 3, "trig_cnt_o after io pulses");
        compare_cnt(drop_cnt, 0, "drop_cnt_o after io pulses");
        trig_mode = trig_pkg::MODE_OFF;
        io_polar  = 1'b0;
        io_input  = 1'b0;
        wait_cycles(4);
    endtask

    task automatic test_overrun();
        int start;
        start = pulse_count;
        setup_soft(4, 4, 0, 20);
        soft_en = 1'b1;
        wait_pulses(start + 1, 100);
        soft_en = 1'b0;
        wait_cycles(4);
        compare_cnt(trig_pkg::cnt_t'(pulse_count - start), 1, "pulses during overrun");
        compare_cnt(trig_cnt, 1, "trig_cnt_o after overrun");
        compare_cnt(drop_cnt, 3, "drop_cnt_o after overrun");
    endtask

    task automatic test_polarity_off();
        int start;
        out_polar = 1'b1;
        next_cycle();
        compare_bit(trigger, 1'b1, "idle trigger_o with out_polar 1");
        start = pulse_count;
        setup_soft(3, 30, random_delay(), 5);
        soft_en = 1'b1;
        wait_pulses(start + 3, 300);
        soft_en = 1'b0;
        next_cycle();
        compare_cnt(trig_cnt, 3, "trig_cnt_o with inverted output");
        compare_bit(trigger, 1'b1, "trigger_o after inverted burst");
        // same burst with no source selected, counters keep 3 and 0
        start      = pulse_count;
        trig_mode  = trig_pkg::MODE_OFF;
        trig_delay = '0;
        soft_en = 1'b1;
        wait_cycles(120);
        soft_en = 1'b0;
        next_cycle();
        compare_cnt(trig_pkg::cnt_t'(pulse_count - start), 0, "pulses in MODE_OFF");
        compare_cnt(trig_cnt, 3, "trig_cnt_o in MODE_OFF");
        compare_cnt(drop_cnt, 0, "drop_cnt_o in MODE_OFF");
    endtask

    initial begin
        seed_dummy = $urandom(SEED);
        rst_n      = 1'b0;
        io_input   = 1'b0;
        encoder_a  = 1'b0;
        encoder_b  = 1'b0;
        trig_mode  = trig_pkg::MODE_OFF;
        io_polar   = 1'b0;
        out_polar  = 1'b0;
        trig_delay = '0;
        trig_width = 1;
        soft_en    = 1'b0;
        soft_cycle = 1;
        soft_num   = '0;
        enc_div    = 1;
        enc_clr    = 1'b0;
        status_clr = 1'b0;
        exp_width  = 1;
        repeat (5) @(posedge clk);
        #(DRIVE_SKEW);
        rst_n = 1'b1;
        next_cycle();
        test_reset();
        test_soft_burst();
        test_encoder();
        test_io_polarity();
        test_overrun();
        test_polarity_off();
        $display("test passed");
        $finish;
    end

endmodule

// File: trigger_manage.f
hdl/trig_pkg.sv
hdl/encoder_divider.sv
hdl/soft_trigger_gen.sv
hdl/trigger_shaper.sv
hdl/trigger_manage_top.sv
sim/tb_clock_gen.sv
sim/trigger_manage_tb.sv

// File: run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f trigger_manage.f \
    --top-module trigger_manage_tb -Mdir obj_dir

if ./obj_dir/Vtrigger_manage_tb | tee /dev/stderr | grep -x "test passed" > /dev/null; then
    exit 0
else
    exit 1
fi
